// File: list.f
panel_pkg.sv
scan_counter.sv
pixel_shader.sv
fm6126_init.sv
panel_driver.sv
hub75_top.sv
tb_hub75_top.sv

// File: Bender.yml
package:
  name: hub75_panel

sources:
  - panel_pkg.sv
  - scan_counter.sv
  - pixel_shader.sv
  - fm6126_init.sv
  - panel_driver.sv
  - hub75_top.sv
  - target: simulation
    files:
      - tb_hub75_top.sv

// File: tb_hub75_top.sv
`default_nettype none

// panel-side model of the HUB75 stream: init writes, startup wait, row scan
module tb_hub75_top
    import panel_pkg::*;
();

    localparam int PWM_BITS       = 3;
    localparam int FRAME_BITS     = 4;
    localparam int STARTUP_CYCLES = 16;

    localparam int SUB_COUNT    = (1 << PWM_BITS) - 1;   // all-ones subframe skipped
    localparam int ROW_COUNT    = 1 << ADDR_BITS;
    localparam int ROW_CYCLES   = 2 * COL_COUNT + 2;
    localparam int FRAME_CYCLES = SUB_COUNT * ROW_COUNT * ROW_CYCLES;
    localparam int INIT_CYCLES  = 10 + 1 + 2 * (2 * COL_COUNT + 1) + STARTUP_CYCLES;
    localparam int MAX_CYCLES   = (5 * FRAME_CYCLES) / 2 + INIT_CYCLES;
    localparam int RUN_FRAMES   = 2;

    typedef enum {
        M_INIT1,
        M_GAP,
        M_INIT2,
        M_STARTUP,
        M_SCAN
    } check_mode_t;

    logic                 clk;
    logic                 pll_locked;
    logic [2:0]           rgb_upper;
    logic [2:0]           rgb_lower;
    logic [ADDR_BITS-1:0] row_addr_out;
    logic                 blank;
    logic                 latch;
    logic                 sclk;

    hub75_top #(
        .PWM_BITS       (PWM_BITS),
        .FRAME_BITS     (FRAME_BITS),
        .STARTUP_CYCLES (STARTUP_CYCLES)
    ) u_hub75_top (
        .clk          (clk),
        .pll_locked   (pll_locked),
        .rgb_upper    (rgb_upper),
        .rgb_lower    (rgb_lower),
        .row_addr_out (row_addr_out),
        .blank        (blank),
        .latch        (latch),
        .sclk         (sclk)
    );

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial
    begin
        pll_locked = 1'b0;
        repeat (10) @(posedge clk);
        pll_locked <= 1'b1;
    end

    // test pattern: red from x, green from y, blue from frame, pwm vs reversed subframe
    function automatic logic [2:0] expected_rgb(input int frm, input int x, input int y,
                                                input int sub);
        int         red;
        int         green;
        int         blue;
        int         rev;
        int         i;
        logic [2:0] bits;
        red   = x >> (COL_BITS - PWM_BITS);
        green = y >> (ADDR_BITS + 1 - PWM_BITS);
        blue  = frm % (1 << PWM_BITS);
        rev   = 0;
        for (i = 0; i < PWM_BITS; i++)
        begin
            if ((sub >> i) & 1)
                rev = rev | (1 << (PWM_BITS - 1 - i));
        end
        bits[0] = (red > rev);
        bits[1] = (green > rev);
        bits[2] = (blue > rev);
        return bits;
    endfunction

    task automatic report_mismatch(input string name, input int exp, input int got);
        $display("FAILED at %0t: %s expected %0h, actual %0h", $time, name, exp, got);
        $display("CHECKS FAILED");
        $fatal(1, "output mismatch");
    endtask

    task automatic report_error(input string what);
        $display("error at %0t: %s", $time, what);
        $display("CHECKS FAILED");
        $fatal(1, "protocol error");
    endtask

    initial
    begin : compare_run
        check_mode_t mode;
        int          pulses;        // sclk pulses in this write or row
        int          wait_cnt;
        int          row;
        int          sub;
        int          frm;
        int          latch_len;
        logic [15:0] word;
        logic        exp_latch;
        logic [2:0]  exp_upper;
        logic [2:0]  exp_lower;
        logic        sclk_q;
        logic        latch_q;
        logic        sclk_rise;
        logic        latch_rise;
        logic        latch_fall;
        logic        latch_hold;

        mode        = M_INIT1;
        pulses      = 0;
        wait_cnt    = 0;
        row         = 0;
        sub         = 0;
        frm         = 0;
        sclk_q      = 1'b0;
        latch_q     = 1'b0;

        @(posedge clk);    // dut registers take their reset values by this edge

        while (frm < RUN_FRAMES)
        begin
            @(posedge clk);    // outputs still hold last cycle's values here
            sclk_rise  = sclk && !sclk_q;
            latch_rise = latch && !latch_q;
            latch_fall = !latch && latch_q;
            latch_hold = latch && latch_q;
            sclk_q     = sclk;
            latch_q    = latch;

            if (!pll_locked)
            begin
                assert (blank === 1'b1 && latch === 1'b0 && sclk === 1'b0 &&
                        rgb_upper === 3'b000 && rgb_lower === 3'b000)
                else report_error("outputs not at reset values while pll_locked is low");
            end
            else
            begin
                case (mode)
                    M_INIT1, M_INIT2:
                    begin
                        word      = (mode == M_INIT1) ? FM_REG1 : FM_REG2;
                        latch_len = (mode == M_INIT1) ? FM_LATCH1 : FM_LATCH2;
                        assert (blank === 1'b1)
                        else report_error("blank dropped during panel init");
                        if (sclk_rise)
                        begin
                            exp_upper = {3{word[15 - (pulses % 16)]}};  // msb first, repeats
                            exp_latch = (pulses >= COL_COUNT - latch_len);
                            assert (rgb_upper === exp_upper)
                            else report_mismatch("rgb_upper", exp_upper, rgb_upper);
                            assert (rgb_lower === exp_upper)
                            else report_mismatch("rgb_lower", exp_upper, rgb_lower);
                            assert (latch === exp_latch)
                            else report_mismatch("latch", exp_latch, latch);
                            pulses++;
                            if (pulses == COL_COUNT)
                            begin
                                pulses = 0;
                                mode   = (mode == M_INIT1) ? M_GAP : M_STARTUP;
                            end
                        end
                    end

                    M_GAP:
                    begin
                        // one idle cycle between the two writes
                        assert (blank === 1'b1 && latch === 1'b0 && sclk === 1'b0)
                        else report_error("no idle cycle between the two register writes");
                        mode = M_INIT2;
                    end

                    M_STARTUP:
                    begin
                        wait_cnt++;
                        if (!blank)
                        begin
                            // end cycle + startup wait + first column low cycle
                            assert (wait_cnt == STARTUP_CYCLES + 2)
                            else report_error("scanning started after a wrong startup wait");
                            mode = M_SCAN;
                        end
                        else
                        begin
                            assert (sclk === 1'b0 && latch === 1'b0)
                            else report_error("sclk or latch active during the startup wait");
                        end
                    end

                    M_SCAN:
                    begin
                        assert (!latch_hold)
                        else report_error("row latch held longer than one cycle");
                        if (sclk_rise)
                        begin
                            assert (pulses < COL_COUNT)
                            else report_error("more than 64 data pulses in one row");
                            assert (blank === 1'b0 && latch === 1'b0)
                            else report_error("panel blanked or latched during a data pulse");
                            exp_upper = expected_rgb(frm, pulses, row, sub);
                            exp_lower = expected_rgb(frm, pulses, row + ROW_COUNT, sub);
                            assert (rgb_upper === exp_upper)
                            else report_mismatch("rgb_upper", exp_upper, rgb_upper);
                            assert (rgb_lower === exp_lower)
                            else report_mismatch("rgb_lower", exp_lower, rgb_lower);
                            pulses++;
                        end
                        if (latch_rise)
                        begin
                            assert (pulses == COL_COUNT)
                            else report_error("row latched before all 64 columns were shifted");
                            assert (blank === 1'b1 && sclk === 1'b0)
                            else report_error("row latch without blank, or with sclk high");
                        end
                        if (latch_fall)
                        begin
                            assert (int'(row_addr_out) == row)
                            else report_mismatch("row_addr_out", row, row_addr_out);
                            assert (blank === 1'b1)
                            else report_error("blank released before the new row address");
                            pulses = 0;
                            row++;
                            if (row == ROW_COUNT)
                            begin
                                row = 0;
                                sub++;
                                if (sub == SUB_COUNT)
                                begin
                                    sub = 0;
                                    frm++;    // blue follows the new frame count
                                end
                            end
                        end
                    end

                    default:
                        mode = M_INIT1;
                endcase
            end
        end

        $display("ALL CHECKS PASSED");
        $finish;
    end

    initial
    begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles < MAX_CYCLES)
        begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: run did not finish within %0d clock cycles", MAX_CYCLES);
        $display("CHECKS FAILED");
        $fatal(1, "timeout");
    end

endmodule

`default_nettype wire

// File: hub75_top.sv
`default_nettype none

// 64x64 HUB75 panel with FM6126 drivers and an in-tree test pattern
module hub75_top
    import panel_pkg::*;
#(
    parameter int PWM_BITS       = 8,
    parameter int FRAME_BITS     = 10,
    parameter int STARTUP_CYCLES = 16
) (
    input  wire                   clk,
    input  wire                   pll_locked,
    output logic [2:0]            rgb_upper,
    output logic [2:0]            rgb_lower,
    output logic [ADDR_BITS-1:0]  row_addr_out,
    output logic                  blank,
    output logic                  latch,
    output logic                  sclk
);

    logic [COL_BITS-1:0]   column;
    logic [ADDR_BITS-1:0]  row_addr;
    logic [PWM_BITS-1:0]   subframe;
    logic [FRAME_BITS-1:0] frame;
    logic [2:0]            shade_upper;
    logic [2:0]            shade_lower;
    logic                  advance;
    logic                  init_start;
    logic                  init_step;
    logic                  second_reg;
    logic                  init_bit;
    logic                  init_latch;
    logic                  init_done;

    scan_counter #(
        .PWM_BITS   (PWM_BITS),
        .FRAME_BITS (FRAME_BITS)
    ) u_scan_counter (
        .clk        (clk),
        .pll_locked (pll_locked),
        .advance    (advance),
        .column     (column),
        .row_addr   (row_addr),
        .subframe   (subframe),
        .frame      (frame)
    );

    pixel_shader #(
        .PWM_BITS   (PWM_BITS),
        .FRAME_BITS (FRAME_BITS)
    ) u_shader_upper (
        .half       (1'b0),
        .column     (column),
        .row_addr   (row_addr),
        .subframe   (subframe),
        .frame      (frame),
        .rgb        (shade_upper)
    );

    pixel_shader #(
        .PWM_BITS   (PWM_BITS),
        .FRAME_BITS (FRAME_BITS)
    ) u_shader_lower (
        .half       (1'b1),       // rows 32..63
        .column     (column),
        .row_addr   (row_addr),
        .subframe   (subframe),
        .frame      (frame),
        .rgb        (shade_lower)
    );

    fm6126_init u_fm6126_init (
        .clk        (clk),
        .pll_locked (pll_locked),
        .init_start (init_start),
        .init_step  (init_step),
        .second_reg (second_reg),
        .init_bit   (init_bit),
        .init_latch (init_latch),
        .init_done  (init_done)
    );

    panel_driver #(
        .STARTUP_CYCLES (STARTUP_CYCLES)
    ) u_panel_driver (
        .clk          (clk),
        .pll_locked   (pll_locked),
        .column       (column),
        .row_addr     (row_addr),
        .rgb_upper_in (shade_upper),
        .rgb_lower_in (shade_lower),
        .init_bit     (init_bit),
        .init_latch   (init_latch),
        .init_done    (init_done),
        .advance      (advance),
        .init_start   (init_start),
        .init_step    (init_step),
        .second_reg   (second_reg),
        .rgb_upper    (rgb_upper),
        .rgb_lower    (rgb_lower),
        .row_addr_out (row_addr_out),
        .blank        (blank),
        .latch        (latch),
        .sclk         (sclk)
    );

endmodule

`default_nettype wire

// File: panel_driver.sv
`default_nettype none

// panel sequencer: FM6126 init, settle wait, then the row scan
//  row = 64 x (SHIFT_LOW, SHIFT_HIGH) + BLANK + UNBLANK = 130 cycles
module panel_driver
    import panel_pkg::*;
#(
    parameter int STARTUP_CYCLES = 16
) (
    input  wire                   clk,
    input  wire                   pll_locked,
    input  wire [COL_BITS-1:0]    column,
    input  wire [ADDR_BITS-1:0]   row_addr,
    input  wire [2:0]             rgb_upper_in,
    input  wire [2:0]             rgb_lower_in,
    input  wire                   init_bit,
    input  wire                   init_latch,
    input  wire                   init_done,
    output logic                  advance,
    output logic                  init_start,
    output logic                  init_step,
    output logic                  second_reg,
    output logic [2:0]            rgb_upper,
    output logic [2:0]            rgb_lower,
    output logic [ADDR_BITS-1:0]  row_addr_out,
    output logic                  blank,
    output logic                  latch,
    output logic                  sclk
);

    localparam int WAIT_BITS = $clog2(STARTUP_CYCLES + 1);

    driver_state_t        state;
    logic                 phase;       // init column half, 0 data / 1 clock
    logic [WAIT_BITS-1:0] wait_cnt;
    logic                 scanning;

    assign scanning = (state == SHIFT_LOW) || (state == SHIFT_HIGH) ||
                      (state == BLANK) || (state == UNBLANK);

    assign advance    = (state == SHIFT_HIGH);
    assign init_start = (state == START) || (state == INIT1_END);
    assign init_step  = ((state == INIT1) || (state == INIT2)) && phase;
    assign second_reg = (state == INIT1_END) || (state == INIT2);

    always_ff @(posedge clk or negedge pll_locked)
    begin
        if (!pll_locked)
        begin
            state        <= START;
            phase        <= 1'b0;
            wait_cnt     <= '0;
            rgb_upper    <= '0;
            rgb_lower    <= '0;
            row_addr_out <= '0;
            blank        <= 1'b1;   // dark until the first row is latched
            latch        <= 1'b0;
            sclk         <= 1'b0;
        end
        else
        begin
            case (state)
                START:
                begin
                    blank <= 1'b1;
                    state <= INIT1;
                end

                INIT1, INIT2:
                begin
                    phase <= ~phase;
                    if (!phase)
                    begin
                        // same bit on all six data lines
                        rgb_upper <= {3{init_bit}};
                        rgb_lower <= {3{init_bit}};
                        latch     <= init_latch;
                        sclk      <= 1'b0;
                    end
                    else
                    begin
                        sclk <= 1'b1;
                        if (init_done)
                            state <= (state == INIT1) ? INIT1_END : INIT2_END;
                    end
                end

                INIT1_END:
                begin
                    latch <= 1'b0;
                    sclk  <= 1'b0;
                    state <= INIT2;
                end

                INIT2_END:
                begin
                    latch     <= 1'b0;
                    sclk      <= 1'b0;
                    rgb_upper <= '0;
                    rgb_lower <= '0;
                    wait_cnt  <= WAIT_BITS'(STARTUP_CYCLES - 1);
                    state     <= STARTUP;
                end

                STARTUP:
                begin
                    if (wait_cnt == '0)
                        state <= SHIFT_LOW;
                    else
                        wait_cnt <= wait_cnt - 1'b1;
                end

                SHIFT_LOW:
                begin
                    rgb_upper <= rgb_upper_in;     // shader output for this column
                    rgb_lower <= rgb_lower_in;
                    blank     <= 1'b0;
                    sclk      <= 1'b0;
                    state     <= SHIFT_HIGH;
                end

                SHIFT_HIGH:
                begin
                    sclk <= 1'b1;
                    if (column == COL_BITS'(COL_COUNT - 1))
                        state <= BLANK;
                    else
                        state <= SHIFT_LOW;
                end

                BLANK:
                begin
                    blank <= 1'b1;
                    latch <= 1'b1;
                    sclk  <= 1'b0;
                    state <= UNBLANK;
                end

                UNBLANK:
                begin
                    // counter already moved on during the last column
                    row_addr_out <= row_addr - 1'b1;
                    latch        <= 1'b0;
                    state        <= SHIFT_LOW;
                end

                default:
                    state <= START;
            endcase
        end
    end

    a_no_latch_clk: assert property (
        @(posedge clk) disable iff (!pll_locked)
        scanning |-> !(latch && sclk)
    );

    // row latch is a single pulse inside the blank window
    a_latch_blanked: assert property (
        @(posedge clk) disable iff (!pll_locked)
        (scanning && $rose(latch)) |-> blank ##1 (!latch && blank)
    );

endmodule

`default_nettype wire

// File: fm6126_init.sv
`default_nettype none

// serial source for the two FM6126 configuration writes
module fm6126_init
    import panel_pkg::*;
(
    input  wire  clk,
    input  wire  pll_locked,
    input  wire  init_start,   // load pattern and column count
    input  wire  init_step,    // one column shifted
    input  wire  second_reg,   // 0 selects FM_REG1, 1 selects FM_REG2
    output logic init_bit,
    output logic init_latch,
    output logic init_done     // high in the last column of the write
);

    logic [15:0]         pattern;     // msb is the bit on the wire
    logic [COL_BITS-1:0] remain;      // columns left after the current one
    logic [COL_BITS-1:0] latch_len;

    assign latch_len = second_reg ? COL_BITS'(FM_LATCH2) : COL_BITS'(FM_LATCH1);

    assign init_bit   = pattern[15];
    assign init_latch = (remain < latch_len);    // last FM_LATCH columns
    assign init_done  = (remain == '0);

    // pattern rotates so the 16-bit word repeats four times per row
    always_ff @(posedge clk)
    begin
        if (init_start)
            pattern <= second_reg ? FM_REG2 : FM_REG1;
        else if (init_step)
            pattern <= {pattern[14:0], pattern[15]};
    end

    always_ff @(posedge clk or negedge pll_locked)
    begin
        if (!pll_locked)
            remain <= '0;
        else if (init_start)
            remain <= COL_BITS'(COL_COUNT - 1);
        else if (init_step && !init_done)
            remain <= remain - 1'b1;
    end

endmodule

`default_nettype wire

// File: pixel_shader.sv
`default_nettype none

// built-in test pattern for one half of the panel, reduced to 1 bit per channel
module pixel_shader
    import panel_pkg::*;
#(
    parameter int PWM_BITS   = 8,
    parameter int FRAME_BITS = 10
) (
    input  wire                   half,       // 0 upper, 1 lower
    input  wire [COL_BITS-1:0]    column,
    input  wire [ADDR_BITS-1:0]   row_addr,
    input  wire [PWM_BITS-1:0]    subframe,
    input  wire [FRAME_BITS-1:0]  frame,
    output logic [2:0]            rgb         // {b, g, r}
);

    logic [ADDR_BITS:0]  y;
    logic [PWM_BITS-1:0] red;
    logic [PWM_BITS-1:0] green;
    logic [PWM_BITS-1:0] blue;
    logic [PWM_BITS-1:0] cmp;

    assign y = {half, row_addr};

    // horizontal ramp in red, vertical ramp in green
    if (PWM_BITS <= COL_BITS)
    begin : g_trunc
        assign red   = column[COL_BITS-1 -: PWM_BITS];
        assign green = y[ADDR_BITS -: PWM_BITS];
    end
    else
    begin : g_ext
        assign red   = PWM_BITS'(column);
        assign green = PWM_BITS'(y);
    end

    assign blue = frame[PWM_BITS-1:0];    // cycles with the frame count

    // bit reversal spreads the on-time over the subframes, less flicker
    always_comb
    begin
        for (int i = 0; i < PWM_BITS; i++)
            cmp[i] = subframe[PWM_BITS-1-i];
    end

    assign rgb[0] = (red > cmp);
    assign rgb[1] = (green > cmp);
    assign rgb[2] = (blue > cmp);

endmodule

`default_nettype wire

// File: scan_counter.sv
`default_nettype none

// column -> row address -> subframe -> frame, stepped by the driver
module scan_counter
    import panel_pkg::*;
#(
    parameter int PWM_BITS   = 8,
    parameter int FRAME_BITS = 10
) (
    input  wire                   clk,
    input  wire                   pll_locked,
    input  wire                   advance,      // one cycle per shifted column
    output logic [COL_BITS-1:0]   column,
    output logic [ADDR_BITS-1:0]  row_addr,
    output logic [PWM_BITS-1:0]   subframe,
    output logic [FRAME_BITS-1:0] frame
);

    // last subframe before wrap; all ones is skipped so full scale is always on
    localparam logic [PWM_BITS-1:0] SUB_LAST = {{(PWM_BITS - 1){1'b1}}, 1'b0};

    logic col_wrap;
    logic row_wrap;
    logic sub_wrap;

    assign col_wrap = (column == '1);
    assign row_wrap = col_wrap && (row_addr == '1);
    assign sub_wrap = row_wrap && (subframe == SUB_LAST);

    always_ff @(posedge clk or negedge pll_locked)
    begin
        if (!pll_locked)
        begin
            column   <= '0;
            row_addr <= '0;
            subframe <= '0;
            frame    <= '0;
        end
        else if (advance)
        begin
            column <= column + 1'b1;
            if (col_wrap)
                row_addr <= row_addr + 1'b1;     // wraps 31 -> 0 by width
            if (row_wrap)
            begin
                if (sub_wrap)
                    subframe <= '0;              // wrap one early
                else
                    subframe <= subframe + 1'b1;
            end
            if (sub_wrap)
                frame <= frame + 1'b1;
        end
    end

    // the compare value in the shader must never be all ones
    a_subframe_skip: assert property (
        @(posedge clk) disable iff (!pll_locked)
        subframe != '1
    );

endmodule

`default_nettype wire

// File: panel_pkg.sv
`default_nettype none

package panel_pkg;

    // panel geometry, two 32-row halves scanned together
    localparam int COL_BITS  = 6;             // 64 columns
    localparam int ADDR_BITS = 5;             // 32 scan rows per half
    localparam int COL_COUNT = 1 << COL_BITS;

    // FM6126 configuration words, shifted msb first and repeated over 64 columns
    localparam logic [15:0] FM_REG1 = 16'h7FFF;
    localparam logic [15:0] FM_REG2 = 16'h0040;

    // latch is held over the tail of each register write
    localparam int FM_LATCH1 = 11;
    localparam int FM_LATCH2 = 12;

    typedef enum logic [3:0] {
        START,        // leave reset, kick off first register write
        INIT1,        // shift FM_REG1
        INIT1_END,
        INIT2,        // shift FM_REG2
        INIT2_END,
        STARTUP,      // settle time before scanning
        SHIFT_LOW,    // data set up, sclk low
        SHIFT_HIGH,   // sclk high, counter steps
        BLANK,        // blank and latch the row just shifted
        UNBLANK       // present new row address
    } driver_state_t;

endpackage

`default_nettype wire
